/* rv_alu_pkg.sv */
`default_nettype none

package rv_alu_pkg;

  localparam int XLEN        = 32;
  localparam int NUM_REGS    = 32;
  localparam int QUEUE_DEPTH = 4;
  localparam int CREDIT_W    = 3;                      // holds 0..QUEUE_DEPTH
  localparam int PTR_W       = $clog2(QUEUE_DEPTH);

  localparam logic [6:0] OPC_OP     = 7'b0110011;      // register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;      // register-immediate

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;          // bit 30 picks sra
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  typedef logic [XLEN-1:0]     word_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [4:0]          shamt_t;
  typedef logic [CREDIT_W-1:0] credit_t;
  typedef logic [PTR_W-1:0]    ptr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_SRL,
    ALU_SRA,
    ALU_XOR,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // one decoded operation as it sits in the queue
  typedef struct packed {
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_imm;                                 // second operand from imm
    word_t    imm;                                     // sign-extended or shamt
  } dec_op_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    value;
  } wb_t;

endpackage

`default_nettype wire

/* instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                instr_valid,
  input  rv_alu_pkg::word_t   instr,
  output logic                instr_ready,
  output logic                push,
  output rv_alu_pkg::dec_op_t push_op,
  input  logic                credit_return
);

  rv_alu_pkg::credit_t credits;                        // free queue slots
  rv_alu_pkg::dec_op_t dec;
  rv_alu_pkg::shamt_t  shamt;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                is_arith;
  logic                accept;
  logic                take;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign shamt    = instr[24:20];
  assign is_arith = (opcode == rv_alu_pkg::OPC_OP) || (opcode == rv_alu_pkg::OPC_OP_IMM);

  assign instr_ready = (credits != '0);
  assign accept      = instr_valid && instr_ready;
  assign take        = accept && is_arith;            // other opcodes are dropped

  always_comb begin
    dec         = '0;
    dec.rd      = instr[11:7];
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.use_imm = (opcode == rv_alu_pkg::OPC_OP_IMM);
    dec.imm     = {{20{instr[31]}}, instr[31:20]};
    case (funct3)
      rv_alu_pkg::F3_ADD_SUB: dec.op = (!dec.use_imm && instr[30]) ? rv_alu_pkg::ALU_SUB
                                                                   : rv_alu_pkg::ALU_ADD;
      rv_alu_pkg::F3_SLL:     dec.op = rv_alu_pkg::ALU_SLL;
      rv_alu_pkg::F3_SLT:     dec.op = rv_alu_pkg::ALU_SLT;
      rv_alu_pkg::F3_SLTU:    dec.op = rv_alu_pkg::ALU_SLTU;
      rv_alu_pkg::F3_XOR:     dec.op = rv_alu_pkg::ALU_XOR;
      rv_alu_pkg::F3_SRL_SRA: dec.op = instr[30] ? rv_alu_pkg::ALU_SRA : rv_alu_pkg::ALU_SRL;
      rv_alu_pkg::F3_OR:      dec.op = rv_alu_pkg::ALU_OR;
      default:                dec.op = rv_alu_pkg::ALU_AND;
    endcase
    // shift-immediates carry only the shift amount
    if (dec.use_imm && (funct3 == rv_alu_pkg::F3_SLL || funct3 == rv_alu_pkg::F3_SRL_SRA)) begin
      dec.imm = rv_alu_pkg::word_t'(shamt);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      credits <= rv_alu_pkg::credit_t'(rv_alu_pkg::QUEUE_DEPTH);
      push    <= 1'b0;
    end else begin
      credits <= credits - rv_alu_pkg::credit_t'(take)
                         + rv_alu_pkg::credit_t'(credit_return);
      push    <= take;                                 // one cycle after accept
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      push_op <= dec;
    end
  end

  // returns never outrun what was taken
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n)
    int'(credits) <= rv_alu_pkg::QUEUE_DEPTH);

endmodule

`default_nettype wire

/* op_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module op_queue (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                push,
  input  rv_alu_pkg::dec_op_t push_op,
  input  logic                pop,
  output logic                not_empty,
  output rv_alu_pkg::dec_op_t head_op,
  output logic                credit_return
);

  rv_alu_pkg::dec_op_t entries [rv_alu_pkg::QUEUE_DEPTH];
  rv_alu_pkg::ptr_t    wr_ptr;
  rv_alu_pkg::ptr_t    rd_ptr;
  logic [rv_alu_pkg::PTR_W:0] count;                   // 0..QUEUE_DEPTH
  logic                do_pop;

  assign not_empty     = (count != '0);
  assign head_op       = entries[rd_ptr];
  assign do_pop        = pop && not_empty;
  assign credit_return = do_pop;                       // slot freed this cycle

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;                       // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entries[wr_ptr] <= push_op;
    end
  end

  // the decoder's credits must keep the queue from overflowing
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n)
    push |-> (int'(count) < rv_alu_pkg::QUEUE_DEPTH) || do_pop);

  // execute only pops what is there
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n)
    pop |-> not_empty);

endmodule

`default_nettype wire

/* alu_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                not_empty,
  input  rv_alu_pkg::dec_op_t head_op,
  output logic                pop,
  output logic                wb_valid,
  output rv_alu_pkg::wb_t     wb,
  input  logic                wb_ready
);

  rv_alu_pkg::word_t  regs [rv_alu_pkg::NUM_REGS];
  rv_alu_pkg::word_t  op_a;
  rv_alu_pkg::word_t  op_b;
  rv_alu_pkg::word_t  result;
  rv_alu_pkg::shamt_t shamt;
  logic               wr_en;

  // pop when the writeback slot is free or draining now
  assign pop   = not_empty && (!wb_valid || wb_ready);
  assign wr_en = pop && (head_op.rd != '0);           // x0 writes are dropped

  assign op_a  = regs[head_op.rs1];
  assign op_b  = head_op.use_imm ? head_op.imm : regs[head_op.rs2];
  assign shamt = op_b[4:0];                            // low 5 bits only

  always_comb begin
    case (head_op.op)
      rv_alu_pkg::ALU_ADD:  result = op_a + op_b;
      rv_alu_pkg::ALU_SUB:  result = op_a - op_b;
      rv_alu_pkg::ALU_SLL:  result = op_a << shamt;
      rv_alu_pkg::ALU_SLT:  result = rv_alu_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_alu_pkg::ALU_SLTU: result = rv_alu_pkg::word_t'(op_a < op_b);
      rv_alu_pkg::ALU_SRL:  result = op_a >> shamt;
      rv_alu_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt;
      rv_alu_pkg::ALU_XOR:  result = op_a ^ op_b;
      rv_alu_pkg::ALU_OR:   result = op_a | op_b;
      default:              result = op_a & op_b;
    endcase
  end

  // register file starts all zero, x0 is never written
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rv_alu_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[head_op.rd] <= result;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else if (wr_en) begin
      wb_valid <= 1'b1;
    end else if (wb_ready) begin
      wb_valid <= 1'b0;                                // accepted, nothing new
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      wb.rd    <= head_op.rd;
      wb.value <= result;
    end
  end

  // writeback holds until the outside takes it
  a_wb_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
    (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb)));

endmodule

`default_nettype wire

/* rv_alu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu_top (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  rv_alu_pkg::word_t instr,
  output logic              instr_ready,
  output logic              wb_valid,
  output rv_alu_pkg::wb_t   wb,
  input  logic              wb_ready
);

  logic                push;
  rv_alu_pkg::dec_op_t push_op;
  logic                credit_return;
  logic                not_empty;
  rv_alu_pkg::dec_op_t head_op;
  logic                pop;

  instr_decode u_decode (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .instr_ready   (instr_ready),
    .push          (push),
    .push_op       (push_op),
    .credit_return (credit_return)
  );

  op_queue u_queue (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .push          (push),
    .push_op       (push_op),
    .pop           (pop),
    .not_empty     (not_empty),
    .head_op       (head_op),
    .credit_return (credit_return)
  );

  alu_execute u_execute (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .not_empty (not_empty),
    .head_op   (head_op),
    .pop       (pop),
    .wb_valid  (wb_valid),
    .wb        (wb),
    .wb_ready  (wb_ready)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_i,
  output logic rst_n
);

  initial begin
    clk_i = 1'b0;
    rst_n <= 1'b0;
    repeat (4) @(posedge clk_i);                       // reset held for 4 cycles
    rst_n <= 1'b1;
  end

  always #5 clk_i = ~clk_i;                            // 10 ns period

endmodule

`default_nettype wire

/* tb_rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_alu;

  localparam int MAX_CASES  = 64;
  localparam int WAIT_LIMIT = 200;

  logic              clk_i;
  logic              rst_n;
  logic              instr_valid;
  rv_alu_pkg::word_t instr;
  logic              instr_ready;
  logic              wb_valid;
  rv_alu_pkg::wb_t   wb;
  logic              wb_ready;

  logic [31:0] case_words [0:4*MAX_CASES-1];           // flag, word, rd, value per case
  int          accept_cycle [MAX_CASES];
  int          num_cases;
  int          next_case;                              // next case owed a writeback
  int          cycle;
  int          errors;
  int          timeouts;
  int          wait_cnt;
  int          idx;
  integer      seed;
  bit          abort;

  tb_clock_gen clk_gen (
    .clk_i (clk_i),
    .rst_n (rst_n)
  );

  rv_alu_top uut (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .wb_ready    (wb_ready)
  );

  // index of the first case at or after from that expects a writeback
  function automatic int next_expected(input int from);
    int i;
    i = from;
    while (i < num_cases && case_words[4*i] != 32'd1) begin
      i++;
    end
    return i;
  endfunction

  always @(posedge clk_i) begin
    cycle    <= cycle + 1;
    wb_ready <= ($random(seed) % 4) != 0;              // stalls about one cycle in four
  end

  // writebacks are compared in order against the cases file
  always @(posedge clk_i) begin
    if (rst_n && wb_valid && wb_ready) begin
      if (next_case >= num_cases) begin
        $display("unexpected writeback to x%0d at %0t ns", wb.rd, $time);
        errors++;
      end else begin
        if (wb.rd != case_words[4*next_case+2][4:0]) begin
          $display("Error at %0t ns: wb.rd expected %0d, got %0d", $time,
                   case_words[4*next_case+2][4:0], wb.rd);
          errors++;
        end
        if (wb.value != case_words[4*next_case+3]) begin
          $display("Error at %0t ns: wb.value expected %h, got %h", $time,
                   case_words[4*next_case+3], wb.value);
          errors++;
        end
        if (cycle - accept_cycle[next_case] < 3) begin
          $display("writeback of case %0d came only %0d cycles after its word", next_case,
                   cycle - accept_cycle[next_case]);
          errors++;
        end
        next_case <= next_expected(next_case + 1);
      end
    end
  end

  initial begin
    seed        = 29856;
    cycle       <= 0;
    errors      = 0;
    timeouts    = 0;
    abort       = 1'b0;
    num_cases   = -1;
    instr_valid <= 1'b0;
    instr       <= '0;
    wb_ready    <= 1'b0;
    $readmemh("alu_cases.mem", case_words);
    for (idx = 0; idx < MAX_CASES; idx++) begin
      if (num_cases < 0 && case_words[4*idx] == 32'd2) begin
        num_cases = idx;
      end
    end
    if (num_cases < 0) begin
      $display("the cases file is missing or has no end marker");
      errors++;
      abort     = 1'b1;
      num_cases = 0;
    end
    next_case <= next_expected(0);

    wait_cnt = 0;
    while (!rst_n && wait_cnt < WAIT_LIMIT) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (!rst_n) begin
      $display("timed out waiting for reset release");
      timeouts++;
      abort = 1'b1;
    end else begin
      if (instr_ready !== 1'b1) begin
        $display("Error at %0t ns: instr_ready expected 1, got %b", $time, instr_ready);
        errors++;
      end
      if (wb_valid !== 1'b0) begin
        $display("Error at %0t ns: wb_valid expected 0, got %b", $time, wb_valid);
        errors++;
      end
    end

    // each word is held until the DUT takes it
    for (idx = 0; idx < num_cases && !abort; idx++) begin
      instr_valid <= 1'b1;
      instr       <= case_words[4*idx+1];
      wait_cnt = 0;
      do begin
        @(posedge clk_i);
        wait_cnt++;
      end while (!instr_ready && wait_cnt < WAIT_LIMIT);
      if (!instr_ready) begin
        $display("timed out waiting for instr_ready on case %0d", idx);
        timeouts++;
        abort = 1'b1;
      end else begin
        accept_cycle[idx] = cycle;
      end
    end
    instr_valid <= 1'b0;

    wait_cnt = 0;
    while (!abort && next_case < num_cases && wait_cnt < WAIT_LIMIT) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (!abort && next_case < num_cases) begin
      $display("timed out waiting for the writeback of case %0d", next_case);
      timeouts++;
    end
    repeat (10) @(posedge clk_i);                      // catch stray writebacks

    $display("checked %0d cases, errors: %0d, timeouts: %0d", num_cases, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* alu_cases.mem */
// columns: writeback flag (1 expected, 0 none, 2 end), instruction, rd, value
// values follow RV32I from an all-zero register file
1 01300093 01 00000013  // addi x1, x0, 19
1 00200113 02 00000002  // addi x2, x0, 2
1 00209193 03 0000004C  // slli x3, x1, 2
1 FFF0A213 04 00000000  // slti x4, x1, -1
1 FFF0B293 05 00000001  // sltiu x5, x1, -1
1 0020D313 06 00000004  // srli x6, x1, 2
1 FED00393 07 FFFFFFED  // addi x7, x0, -19
1 4023D413 08 FFFFFFFB  // srai x8, x7, 2
1 0020C493 09 00000011  // xori x9, x1, 2
1 0020E513 0A 00000013  // ori x10, x1, 2
1 0020F593 0B 00000002  // andi x11, x1, 2
1 00208733 0E 00000015  // add x14, x1, x2
1 402087B3 0F 00000011  // sub x15, x1, x2
1 00209833 10 0000004C  // sll x16, x1, x2
1 0020A8B3 11 00000000  // slt x17, x1, x2
1 00113933 12 00000001  // sltu x18, x2, x1
1 0020D9B3 13 00000004  // srl x19, x1, x2
1 4023DA33 14 FFFFFFFB  // sra x20, x7, x2
1 0020CAB3 15 00000011  // xor x21, x1, x2
1 0020EB33 16 00000013  // or x22, x1, x2
1 0020FBB3 17 00000002  // and x23, x1, x2
1 02200C93 19 00000022  // addi x25, x0, 34
1 01909D33 1A 0000004C  // sll x26, x1, x25
1 00E70DB3 1B 0000002A  // add x27, x14, x14
1 FFED8D93 1B 00000028  // addi x27, x27, -2
1 401D8E33 1C 00000015  // sub x28, x27, x1
0 00508013 00 00000000  // addi x0, x1, 5
0 0000AE83 00 00000000  // lw x29, 0(x1)
1 00100EB3 1D 00000013  // add x29, x0, x1
2 00000000 00 00000000  // end of cases

/* project.f */
rv_alu_pkg.sv
instr_decode.sv
op_queue.sv
alu_execute.sv
rv_alu_top.sv
tb_clock_gen.sv
tb_rv_alu.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= tb_rv_alu
FILELIST ?= project.f
FLAGS    ?= --binary --timing --assert -j 0
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Everything OK

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(wildcard *.sv)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
